// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = axiBridgeTb
FILELIST = tb.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: bench/axiBridgeTb.sv
`timescale 1ns/10ps

module axiBridgeTb import axiPkg::*; import cpuPortPkg::*; ();

    localparam word_t readKey = 32'ha5a50000;    // slave data is address xor this.
    localparam int waitLimit = 200;

    logic clk, rst;
    logic instReqValid, instReqReady, instRespValid, instRespReady;
    addr_t instReqPc;
    cacheLine_t instRespLine;
    logic dataReqValid, dataReqWen, dataReqReady, dataRespValid, dataRespReady;
    addr_t dataReqAddr;
    word_t dataReqWdata, dataRespData;
    strobe_t dataReqStrobe;
    axiId_t arId, awId;
    addr_t arAddr, awAddr;
    axiLen_t arLen, awLen;
    axiSize_t arSize, awSize;
    axiBurst_t arBurst, awBurst;
    logic arValid, rReady, awValid, wValid, wLast, bReady;
    word_t wData;
    strobe_t wStrobe;
    logic arReady = 1'b0;
    logic rValid = 1'b0;
    logic rLast = 1'b0;
    word_t rData = '0;
    logic awReady = 1'b0;
    logic wReady = 1'b0;
    logic bValid = 1'b0;

    integer seed = 32'hb389d065;
    logic [44:0] arLog[$];
    logic [44:0] awLog[$];
    logic [36:0] wLog[$];
    int bCount = 0;
    addr_t rBase = '0;
    axiLen_t rLen = '0;
    axiLen_t rBeat = '0;
    logic rActive = 1'b0;
    logic bPend = 1'b0;

    clockGen gen (.clk(clk), .rst(rst));

    axiBridge UUT (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI slave model with random gaps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        if (rst) begin
            arReady <= 1'b0;
            awReady <= 1'b0;
            wReady <= 1'b0;
            rValid <= 1'b0;
            bValid <= 1'b0;
            rActive <= 1'b0;
            bPend <= 1'b0;
        end else begin
            arReady <= rnd[0];
            awReady <= rnd[1];
            wReady <= rnd[2];
            if (arValid && arReady) begin
                arLog.push_back({arId, arAddr, arLen, arSize, arBurst});
                rBase <= arAddr;
                rLen <= arLen;
                rBeat <= '0;
                rActive <= 1'b1;
            end
            if (rValid && rReady) begin
                rValid <= 1'b0;
                rBeat <= rBeat + 4'd1;
                if (rLast) rActive <= 1'b0;
            end else if (rActive && !rValid && rnd[3]) begin
                rValid <= 1'b1;
                rData <= (rBase + {26'b0, rBeat, 2'b00}) ^ readKey;
                rLast <= rBeat == rLen;
            end
            if (awValid && awReady) awLog.push_back({awId, awAddr, awLen, awSize, awBurst});
            if (wValid && wReady) begin
                wLog.push_back({wData, wStrobe, wLast});
                bPend <= 1'b1;
            end
            if (bValid && bReady) begin
                bValid <= 1'b0;
                bCount <= bCount + 1;
            end else if (bPend && !bValid && rnd[4]) begin
                bValid <= 1'b1;
                bPend <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkLine(input string name, input cacheLine_t got, input cacheLine_t exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t: %s got %h expected %h",
                                      $time, name, got.flat, exp.flat));
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic checkField(input string name, input axiLen_t got, input axiLen_t exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stopWithFailure($sformatf("error at %0t: %s got %b expected %b",
                                      $time, name, got, exp));
    endtask

    // every address phase of this bridge carries four bytes per beat.
    task automatic checkAddrPhase(input string ch, input logic [44:0] e, input axiId_t id,
                                  input addr_t addr, input axiLen_t len, input axiBurst_t burst);
        checkField({ch, "Id"}, e[44:41], id);
        checkAddr({ch, "Addr"}, e[40:9], addr);
        checkField({ch, "Len"}, e[8:5], len);
        checkField({ch, "Size"}, {1'b0, e[4:2]}, 4'd2);
        checkField({ch, "Burst"}, {2'b00, e[1:0]}, {2'b00, burst});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic sendRequest(input logic inst, input logic data, input addr_t pc,
                               input addr_t addr, input logic wen, input word_t wdata,
                               input strobe_t strobe);
        int n;
        @(posedge clk);
        instReqValid <= inst;
        instReqPc <= pc;
        dataReqValid <= data;
        dataReqAddr <= addr;
        dataReqWen <= wen;
        dataReqWdata <= wdata;
        dataReqStrobe <= strobe;
        @(negedge clk);
        for (n = 0; n < waitLimit && !((!inst || instReqReady) && (!data || dataReqReady)); n++)
            @(negedge clk);
        if (!((!inst || instReqReady) && (!data || dataReqReady)))
            stopWithFailure("timeout waiting for a request ready");
        @(posedge clk);    // both requests are taken on this edge.
        instReqValid <= 1'b0;
        dataReqValid <= 1'b0;
    endtask

    task automatic takeInst(input cacheLine_t exp);
        int n;
        int stretch;
        cacheLine_t held;
        for (n = 0; n < waitLimit && instRespValid !== 1'b1; n++) @(negedge clk);
        if (instRespValid !== 1'b1)
            stopWithFailure("timeout waiting for the instruction response");
        held = instRespLine;
        stretch = 1 + int'($random(seed) & 7);
        repeat (stretch) begin
            checkFlag("instRespValid", instRespValid, 1'b1);
            checkLine("instRespLine", instRespLine, held);
            checkFlag("arValid", arValid, 1'b0);
            @(negedge clk);
        end
        checkLine("instRespLine", instRespLine, exp);
        @(posedge clk);
        instRespReady <= 1'b1;
        @(posedge clk);
        instRespReady <= 1'b0;
    endtask

    task automatic takeData(input word_t exp);
        int n;
        for (n = 0; n < waitLimit && dataRespValid !== 1'b1; n++) @(negedge clk);
        if (dataRespValid !== 1'b1) stopWithFailure("timeout waiting for the data response");
        checkWord("dataRespData", dataRespData, exp);
        @(posedge clk);
        dataRespReady <= 1'b1;
        @(posedge clk);
        dataRespReady <= 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int fd;
        int n;
        int done;
        int bBefore;
        string line;
        logic [3:0] kind;
        addr_t addr;
        word_t wdata;
        word_t word;
        logic [3:0] strobe;
        logic [127:0] lineVal;
        logic [36:0] w;

        instReqValid = 1'b0;
        instReqPc = '0;
        instRespReady = 1'b0;
        dataReqValid = 1'b0;
        dataReqAddr = '0;
        dataReqWen = 1'b0;
        dataReqWdata = '0;
        dataReqStrobe = '0;
        dataRespReady = 1'b0;
        done = 0;

        @(negedge clk);
        for (n = 0; n < waitLimit && rst; n++) @(negedge clk);
        if (rst) stopWithFailure("reset never went low");
        checkFlag("arValid", arValid, 1'b0);
        checkFlag("awValid", awValid, 1'b0);
        checkFlag("wValid", wValid, 1'b0);
        checkFlag("rReady", rReady, 1'b0);
        checkFlag("bReady", bReady, 1'b0);
        checkFlag("instRespValid", instRespValid, 1'b0);
        checkFlag("dataRespValid", dataRespValid, 1'b0);
        checkFlag("instReqReady", instReqReady, 1'b1);
        checkFlag("dataReqReady", dataReqReady, 1'b1);

        fd = $fopen("bench/bridgeGolden.txt", "r");
        if (fd == 0) stopWithFailure("cannot open the golden file");
        while ($fgets(line, fd) != 0) begin
            // comment and blank lines do not scan and are skipped.
            if ($sscanf(line, "%h %h %h %h %h %h",
                        kind, addr, wdata, strobe, word, lineVal) == 6) begin
                case (kind)
                    4'h1: begin
                        // a data read queued behind the fetch must wait for the held line.
                        sendRequest(1'b1, 1'b0, addr, '0, 1'b0, '0, '0);
                        sendRequest(1'b0, 1'b1, '0, addr, 1'b0, '0, '0);
                        takeInst(lineVal);
                        takeData(lineVal[addr[3:2]*32 +: 32]);
                        checkAddrPhase("ar", arLog.pop_front(), 4'd0,
                                       addr & ~32'hf, 4'd3, 2'd2);
                        checkAddrPhase("ar", arLog.pop_front(), 4'd1, addr, 4'd0, 2'd2);
                    end
                    4'h2: begin
                        sendRequest(1'b0, 1'b1, '0, addr, 1'b0, '0, '0);
                        takeData(word);
                        checkAddrPhase("ar", arLog.pop_front(), 4'd1, addr, 4'd0, 2'd2);
                    end
                    4'h3: begin
                        bBefore = bCount;
                        sendRequest(1'b0, 1'b1, '0, addr, 1'b1, wdata, strobe);
                        @(negedge clk);
                        for (n = 0; n < waitLimit && dataReqReady !== 1'b1; n++)
                            @(negedge clk);
                        if (dataReqReady !== 1'b1)
                            stopWithFailure("timeout waiting for write completion");
                        if (bCount != bBefore + 1)
                            stopWithFailure("dataReqReady returned before the B handshake");
                        checkAddrPhase("aw", awLog.pop_front(), 4'd0, addr, 4'd0, 2'd1);
                        w = wLog.pop_front();
                        checkWord("wData", w[36:5], word);
                        checkField("wStrobe", w[4:1], strobe);
                        checkFlag("wLast", w[0], 1'b1);
                    end
                    4'h4: begin
                        // the data read must reach the bus first.
                        sendRequest(1'b1, 1'b1, wdata, addr, 1'b0, '0, '0);
                        takeData(word);
                        takeInst(lineVal);
                        checkAddrPhase("ar", arLog.pop_front(), 4'd1, addr, 4'd0, 2'd2);
                        checkAddrPhase("ar", arLog.pop_front(), 4'd0,
                                       wdata & ~32'hf, 4'd3, 2'd2);
                    end
                    default: stopWithFailure("unknown transaction kind in the golden file");
                endcase
                done++;
            end
        end
        $fclose(fd);

        if (done == 0) begin
            stopWithFailure("the golden file held no transactions");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

// File: bench/bridgeGolden.txt
# kind addr wdata strobe word line (1 fetch, 2 read, 3 write, 4 fetch and read)
# kind 4 reads at addr and fetches the line at the pc given in the wdata column
1 00002008 00000000 0 00000000 a5a5200ca5a52008a5a52004a5a52000
2 00001234 00000000 0 a5a51234 00000000000000000000000000000000
3 00003000 deadbeef 5 deadbeef 00000000000000000000000000000000
4 00004010 00005004 0 a5a54010 a5a5500ca5a55008a5a55004a5a55000
1 0000601c 00000000 0 00000000 a5a5601ca5a56018a5a56014a5a56010
3 00007004 12345678 f 12345678 00000000000000000000000000000000
2 00008ffc 00000000 0 a5a58ffc 00000000000000000000000000000000

// File: bench/bridge_properties.sv
`timescale 1ns/10ps

module readProps (
    input logic clk,
    input logic rst,
    input logic arValid,
    input logic arReady,
    input logic [31:0] arAddr,
    input logic [3:0] arId,
    input logic rReady,
    input logic instRespValid,
    input logic instRespReady,
    input logic dataRespValid,
    input logic dataRespReady
);

    arHold: assert property (@(posedge clk) disable iff (rst)
        arValid && !arReady |=> arValid && $stable(arAddr) && $stable(arId))
        else $error("arValid or its payload changed before arReady");

    instRespHold: assert property (@(posedge clk) disable iff (rst)
        instRespValid && !instRespReady |=> instRespValid)
        else $error("instRespValid dropped before instRespReady");

    dataRespHold: assert property (@(posedge clk) disable iff (rst)
        dataRespValid && !dataRespReady |=> dataRespValid)
        else $error("dataRespValid dropped before dataRespReady");

    // no beat may be taken while a response is still waiting.
    noBeatInResp: assert property (@(posedge clk) disable iff (rst)
        !(rReady && (instRespValid || dataRespValid)))
        else $error("rReady high while a response is pending");

endmodule

module writeProps (
    input logic clk,
    input logic rst,
    input logic awValid,
    input logic awReady,
    input logic [31:0] awAddr,
    input logic wValid,
    input logic wReady,
    input logic [31:0] wData,
    input logic bValid,
    input logic bReady
);

    awHold: assert property (@(posedge clk) disable iff (rst)
        awValid && !awReady |=> awValid && $stable(awAddr))
        else $error("awValid or awAddr changed before awReady");

    wHold: assert property (@(posedge clk) disable iff (rst)
        wValid && !wReady |=> wValid && $stable(wData))
        else $error("wValid or wData changed before wReady");

    wAfterAw: assert property (@(posedge clk) disable iff (rst)
        $rose(wValid) |-> $past(awValid && awReady))
        else $error("wValid rose without an AW handshake");

    bWait: assert property (@(posedge clk) disable iff (rst)
        bReady && !bValid |=> bReady)
        else $error("bReady dropped before bValid");

endmodule

bind readEngine readProps readCheck (.*);
bind writeEngine writeProps writeCheck (.*);

// File: bench/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period.
    end

    // reset stays high for the first four rising edges.
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: logic/axiBridge.sv
`timescale 1ns/10ps

module axiBridge
    import axiPkg::*;
    import cpuPortPkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       instReqValid,
    input  addr_t      instReqPc,
    output logic       instReqReady,
    output logic       instRespValid,
    output cacheLine_t instRespLine,
    input  logic       instRespReady,

    input  logic       dataReqValid,
    input  addr_t      dataReqAddr,
    input  logic       dataReqWen,
    input  word_t      dataReqWdata,
    input  strobe_t    dataReqStrobe,
    output logic       dataReqReady,
    output logic       dataRespValid,
    output word_t      dataRespData,
    input  logic       dataRespReady,

    output axiId_t     arId,
    output addr_t      arAddr,
    output axiLen_t    arLen,
    output axiSize_t   arSize,
    output axiBurst_t  arBurst,
    output logic       arValid,
    input  logic       arReady,

    input  word_t      rData,
    input  logic       rLast,
    input  logic       rValid,
    output logic       rReady,

    output axiId_t     awId,
    output addr_t      awAddr,
    output axiLen_t    awLen,
    output axiSize_t   awSize,
    output axiBurst_t  awBurst,
    output logic       awValid,
    input  logic       awReady,

    output word_t      wData,
    output strobe_t    wStrobe,
    output logic       wLast,
    output logic       wValid,
    input  logic       wReady,

    input  logic       bValid,
    output logic       bReady
);

    pendingIf pend ();

    requestSlots slots (.*);

    // read and write channels run on their own, sharing only the slots.
    readEngine reader (.*);

    writeEngine writer (.*);

endmodule

// File: logic/axiPkg.sv
package axiPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [3:0] axiId_t;
    typedef logic [3:0] axiLen_t;    // beats minus one.
    typedef logic [2:0] axiSize_t;   // log2 of the bytes in one beat.
    typedef logic [1:0] axiBurst_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings used by the bridge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam axiId_t instId = 4'd0;
    localparam axiId_t dataId = 4'd1;
    localparam axiId_t writeId = 4'd0;

    localparam axiLen_t lineLen = 4'd3;    // a cache line is four beats.
    localparam axiLen_t singleLen = 4'd0;

    localparam axiSize_t wordSize = 3'd2;

    // the fixed burst type (0) is never issued.
    localparam axiBurst_t burstIncr = 2'd1;
    localparam axiBurst_t burstWrap = 2'd2;

endpackage

// File: logic/cpuPortPkg.sv
package cpuPortPkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strobe_t;    // one enable per byte of word_t.

    localparam int wordsPerLine = 4;
    localparam int lineOffsetBits = 4;

    typedef logic [$clog2(wordsPerLine)-1:0] beatIndex_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The CPU sees one flat line while the assembler fills it word by word.
    // Word 0 sits in the low bits, so the lowest address ends up lowest.
    typedef union packed {
        logic [wordsPerLine*32-1:0] flat;
        word_t [wordsPerLine-1:0] words;
    } cacheLine_t;

endpackage

// File: logic/lineAssembler.sv
`timescale 1ns/10ps

module lineAssembler import cpuPortPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       beatTake,
    input  word_t      beatData,
    output cacheLine_t line
);

    beatIndex_t beatCount;

    // The counter rolls over after the last beat of a line,
    // so every burst starts again at word 0.
    always_ff @(posedge clk) begin
        if (rst) begin
            beatCount <= '0;
        end else if (beatTake) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beatTake) begin
            line.words[beatCount] <= beatData;    // the line holds between bursts.
        end
    end

endmodule

// File: logic/pendingIf.sv
`timescale 1ns/10ps

interface pendingIf import cpuPortPkg::*; ();

    logic instBusy;
    addr_t instPc;

    logic dataBusy;
    addr_t dataAddr;
    logic dataWen;
    word_t dataWdata;
    strobe_t dataStrobe;

    // one-cycle pulses that free a slot.
    logic instDone;
    logic readDone;
    logic writeDone;

    modport slots (
        output instBusy, instPc, dataBusy, dataAddr, dataWen, dataWdata, dataStrobe,
        input instDone, readDone, writeDone
    );

    modport reader (
        input instBusy, instPc, dataBusy, dataAddr, dataWen,
        output instDone, readDone
    );

    modport writer (
        input dataBusy, dataAddr, dataWen, dataWdata, dataStrobe,
        output writeDone
    );

endinterface

// File: logic/readEngine.sv
`timescale 1ns/10ps

module readEngine
    import axiPkg::*;
    import cpuPortPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    pendingIf.reader   pend,

    output axiId_t     arId,
    output addr_t      arAddr,
    output axiLen_t    arLen,
    output axiSize_t   arSize,
    output axiBurst_t  arBurst,
    output logic       arValid,
    input  logic       arReady,

    input  word_t      rData,
    input  logic       rLast,
    input  logic       rValid,
    output logic       rReady,

    output logic       instRespValid,
    output cacheLine_t instRespLine,
    input  logic       instRespReady,
    output logic       dataRespValid,
    output word_t      dataRespData,
    input  logic       dataRespReady
);

    typedef enum logic [2:0] {
        rsIdle,
        rsAddr,
        rsDataBeat,
        rsInstBeats,
        rsRespWait
    } readState_t;

    readState_t state;
    logic forData;      // set when the current read serves the data slot.
    logic dataPending;
    logic respTake;

    assign dataPending = pend.dataBusy && !pend.dataWen;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rsIdle;
            forData <= 1'b0;
        end else begin
            case (state)
                rsIdle: begin
                    if (dataPending) begin    // data reads go ahead of fetches.
                        forData <= 1'b1;
                        state <= rsAddr;
                    end else if (pend.instBusy) begin
                        forData <= 1'b0;
                        state <= rsAddr;
                    end
                end
                rsAddr: begin
                    if (arReady) begin
                        if (forData) begin
                            state <= rsDataBeat;
                        end else begin
                            state <= rsInstBeats;
                        end
                    end
                end
                rsDataBeat, rsInstBeats: begin
                    if (rValid && rLast) begin
                        state <= rsRespWait;
                    end
                end
                rsRespWait: begin
                    if (respTake) begin
                        state <= rsIdle;
                    end
                end
                default: begin
                    state <= rsIdle;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign arValid = state == rsAddr;
    assign arId = forData ? dataId : instId;
    assign arAddr = forData ? pend.dataAddr
                            : {pend.instPc[31:lineOffsetBits], {lineOffsetBits{1'b0}}};
    assign arLen = forData ? singleLen : lineLen;
    assign arSize = wordSize;
    assign arBurst = burstWrap;

    assign rReady = (state == rsDataBeat) || (state == rsInstBeats);

    lineAssembler assembler (
        .clk      (clk),
        .rst      (rst),
        .beatTake (state == rsInstBeats && rValid),
        .beatData (rData),
        .line     (instRespLine)
    );

    always_ff @(posedge clk) begin
        if (state == rsDataBeat && rValid) begin
            dataRespData <= rData;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign instRespValid = state == rsRespWait && !forData;
    assign dataRespValid = state == rsRespWait && forData;

    assign pend.instDone = instRespValid && instRespReady;
    assign pend.readDone = dataRespValid && dataRespReady;
    assign respTake = (instRespValid && instRespReady) || (dataRespValid && dataRespReady);

endmodule

// File: logic/requestSlots.sv
`timescale 1ns/10ps

module requestSlots import cpuPortPkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    instReqValid,
    input  addr_t   instReqPc,
    output logic    instReqReady,

    input  logic    dataReqValid,
    input  addr_t   dataReqAddr,
    input  logic    dataReqWen,
    input  word_t   dataReqWdata,
    input  strobe_t dataReqStrobe,
    output logic    dataReqReady,

    pendingIf.slots pend
);

    logic instTake;
    logic dataTake;
    logic dataDone;

    assign instReqReady = !pend.instBusy;
    assign dataReqReady = !pend.dataBusy;

    assign instTake = instReqValid && instReqReady;
    assign dataTake = dataReqValid && dataReqReady;

    // the data slot is freed by whichever engine served it.
    assign dataDone = pend.readDone || pend.writeDone;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction slot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            pend.instBusy <= 1'b0;
        end else if (instTake) begin
            pend.instBusy <= 1'b1;
        end else if (pend.instDone) begin
            pend.instBusy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instTake) begin
            pend.instPc <= instReqPc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data slot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            pend.dataBusy <= 1'b0;
        end else if (dataTake) begin
            pend.dataBusy <= 1'b1;
        end else if (dataDone) begin
            pend.dataBusy <= 1'b0;
        end
    end

    // the engines look at dataWen only while the slot is busy.
    always_ff @(posedge clk) begin
        if (dataTake) begin
            pend.dataAddr <= dataReqAddr;
            pend.dataWen <= dataReqWen;
            pend.dataWdata <= dataReqWdata;
            pend.dataStrobe <= dataReqStrobe;
        end
    end

endmodule

// File: logic/writeEngine.sv
`timescale 1ns/10ps

module writeEngine
    import axiPkg::*;
    import cpuPortPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    pendingIf.writer  pend,

    output axiId_t    awId,
    output addr_t     awAddr,
    output axiLen_t   awLen,
    output axiSize_t  awSize,
    output axiBurst_t awBurst,
    output logic      awValid,
    input  logic      awReady,

    output word_t     wData,
    output strobe_t   wStrobe,
    output logic      wLast,
    output logic      wValid,
    input  logic      wReady,

    input  logic      bValid,
    output logic      bReady
);

    typedef enum logic [1:0] {
        wsIdle,
        wsAddr,
        wsData,
        wsResp
    } writeState_t;

    writeState_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wsIdle;
        end else begin
            case (state)
                wsIdle:  if (pend.dataBusy && pend.dataWen) state <= wsAddr;
                wsAddr:  if (awReady) state <= wsData;
                wsData:  if (wReady) state <= wsResp;
                wsResp:  if (bValid) state <= wsIdle;
                default: state <= wsIdle;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // channels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign awValid = state == wsAddr;
    assign awId = writeId;
    assign awAddr = pend.dataAddr;
    assign awLen = singleLen;
    assign awSize = wordSize;
    assign awBurst = burstIncr;

    assign wValid = state == wsData;
    assign wData = pend.dataWdata;
    assign wStrobe = pend.dataStrobe;
    assign wLast = 1'b1;    // every write is a single beat.

    assign bReady = state == wsResp;

    // any B ends the write whatever its response code.
    assign pend.writeDone = bValid && bReady;

endmodule

// File: tb.f
logic/axiPkg.sv
logic/cpuPortPkg.sv
logic/pendingIf.sv
logic/requestSlots.sv
logic/lineAssembler.sv
logic/readEngine.sv
logic/writeEngine.sv
logic/axiBridge.sv
bench/clockGen.sv
bench/bridge_properties.sv
bench/axiBridgeTb.sv
